/* usart_config.svh */
`ifndef USART_CONFIG_SVH
`define USART_CONFIG_SVH

// Register map on the byte bus
`define USART_UDR_ADDR    12'h0C6
`define USART_UCSRA_ADDR  12'h0C0
`define USART_UCSRB_ADDR  12'h0C1
`define USART_UCSRC_ADDR  12'h0C2
`define USART_UBRRH_ADDR  12'h0C5
`define USART_UBRRL_ADDR  12'h0C4

// Baud ticks per bit
`define USART_OVERSAMPLE  16

// Majority sample points, first to last
`define USART_SAMPLE_TICKS {4'd7, 4'd8, 4'd9}

`define USART_RX_DEPTH    2
`define USART_TX_DEPTH    1

`endif

/* usart_pkg.sv */
package usart_pkg;

	typedef enum logic [1:0] {
		PAR_NONE = 2'd0,
		PAR_EVEN = 2'd2,
		PAR_ODD  = 2'd3
	} parity_e;

	typedef struct packed {
		logic       rxc;
		logic       txc;
		logic       udre;
		logic       fe;
		logic       dor;
		logic       upe;
		logic [1:0] rsvd;   // Always zero
	} ucsra_t;

	typedef struct packed {
		logic       rxcie;
		logic       txcie;
		logic       udrie;
		logic       rxen;
		logic       txen;
		logic [2:0] rsvd;
	} ucsrb_t;

	typedef struct packed {
		logic [1:0] rsvd_hi;
		logic [1:0] upm;
		logic       usbs;
		logic [1:0] ucsz;   // 0 to 3 gives 5 to 8 data bits
		logic       rsvd_lo;
	} ucsrc_t;

	// Settings seen by the receiver and the transmitter
	typedef struct packed {
		logic       rxen;
		logic       txen;
		logic [1:0] char_size;
		parity_e    parity;
		logic       two_stop;
	} usart_ctrl_t;

	typedef struct packed {
		logic [7:0] data;
		logic       fe;
		logic       pe;
	} rx_frame_t;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA} rx_state_e;

	typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_e;

endpackage

/* usart_baud_gen.sv */
module usart_baud_gen (
	input  logic        cp2,
	input  logic        ireset,
	input  logic [11:0] divisor_i,
	input  logic        load_i,
	output logic        tick_o
);

	logic [11:0] cnt;

	// One tick every divisor+1 cycles
	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			cnt <= '0;
		end else begin
			if (load_i || (cnt == 12'd0))
				cnt <= divisor_i;
			else
				cnt <= cnt - 12'd1;
		end
	end

	assign tick_o = (cnt == 12'd0) && !load_i;   // No stray tick on a rate change

endmodule

/* usart_fifo.sv */
module usart_fifo #(
	parameter int DEPTH = 2,
	parameter int WIDTH = 8
) (
	input  logic             cp2,
	input  logic             ireset,
	input  logic             flush_i,
	input  logic             push_i,
	input  logic [WIDTH-1:0] data_i,
	input  logic             pop_i,
	output logic [WIDTH-1:0] data_o,
	output logic             empty_o,
	output logic             full_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge cp2) begin
		if (do_push && !flush_i)
			mem[wr_ptr] <= data_i;
	end

	assign data_o  = mem[rd_ptr];   // Head entry, no read latency
	assign empty_o = (count == '0);
	assign full_o  = (count == CNT_W'(DEPTH));

endmodule

/* usart_rx.sv */
`include "usart_config.svh"

module usart_rx (
	input  logic                   cp2,
	input  logic                   ireset,
	input  usart_pkg::usart_ctrl_t ctrl_i,
	input  logic                   tick_i,
	input  logic                   rxd_i,
	input  logic                   fifo_full_i,
	output usart_pkg::rx_frame_t   frame_o,
	output logic                   push_o,
	output logic                   overrun_o
);

	localparam logic [11:0] SAMPLE_TICKS = `USART_SAMPLE_TICKS;
	localparam logic [3:0]  LAST_TICK    = 4'(`USART_OVERSAMPLE - 1);

	usart_pkg::rx_state_e state;
	logic [1:0] sync;
	logic [3:0] tick_cnt;
	logic [3:0] bit_idx;
	logic [1:0] samp;       // Earlier two of the three samples
	logic [7:0] data;
	logic       par_bit;
	logic       rx_s;
	logic       vote_en;
	logic       vote;
	logic       par_en;
	logic       par_odd;
	logic       stop_en;
	logic [3:0] nbits;
	logic [3:0] stop_idx;

	assign rx_s     = sync[1];
	assign par_en   = (ctrl_i.parity == usart_pkg::PAR_EVEN) ||
	                  (ctrl_i.parity == usart_pkg::PAR_ODD);
	assign par_odd  = (ctrl_i.parity == usart_pkg::PAR_ODD);
	assign nbits    = 4'd5 + {2'b00, ctrl_i.char_size};
	assign stop_idx = nbits + {3'b000, par_en};
	assign vote_en  = tick_i && (tick_cnt == SAMPLE_TICKS[3:0]);   // Third sample
	assign vote     = (samp[1] & samp[0]) | (samp[1] & rx_s) | (samp[0] & rx_s);
	assign stop_en  = (state == usart_pkg::RX_DATA) && vote_en && (bit_idx == stop_idx);

	// Two-stage synchronizer, idles high
	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset)
			sync <= 2'b11;
		else
			sync <= {sync[0], rxd_i};
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			state    <= usart_pkg::RX_IDLE;
			tick_cnt <= '0;
			bit_idx  <= '0;
		end else begin
			if (state == usart_pkg::RX_IDLE)
				tick_cnt <= '0;   // Bit timing starts at the falling edge
			else if (tick_i)
				tick_cnt <= (tick_cnt == LAST_TICK) ? 4'd0 : tick_cnt + 4'd1;
			if (!ctrl_i.rxen) begin
				state <= usart_pkg::RX_IDLE;
			end else begin
				case (state)
					usart_pkg::RX_IDLE:
						if (!rx_s)
							state <= usart_pkg::RX_START;
					usart_pkg::RX_START: begin
						bit_idx <= '0;
						if (vote_en)
							state <= vote ? usart_pkg::RX_IDLE : usart_pkg::RX_DATA;   // Glitch rejected
					end
					usart_pkg::RX_DATA: begin
						if (vote_en)
							bit_idx <= bit_idx + 4'd1;
						if (stop_en)
							state <= usart_pkg::RX_IDLE;   // Back to idle mid stop bit
					end
					default:
						state <= usart_pkg::RX_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge cp2) begin
		if (tick_i && ((tick_cnt == SAMPLE_TICKS[11:8]) || (tick_cnt == SAMPLE_TICKS[7:4])))
			samp <= {samp[0], rx_s};
		if (state == usart_pkg::RX_START) begin
			data <= '0;   // Keeps unused high bits at zero
		end else if ((state == usart_pkg::RX_DATA) && vote_en) begin
			if (bit_idx < nbits)
				data[bit_idx[2:0]] <= vote;   // LSB first
			else if (bit_idx == nbits)
				par_bit <= vote;
		end
	end

	assign frame_o.data = data;
	assign frame_o.fe   = !vote;
	assign frame_o.pe   = par_en && (par_bit != (^data ^ par_odd));
	assign push_o       = stop_en && !fifo_full_i;
	assign overrun_o    = stop_en && fifo_full_i;

endmodule

/* usart_tx.sv */
`include "usart_config.svh"

module usart_tx (
	input  logic                   cp2,
	input  logic                   ireset,
	input  usart_pkg::usart_ctrl_t ctrl_i,
	input  logic                   tick_i,
	input  logic                   fifo_empty_i,
	input  logic [7:0]             fifo_data_i,
	output logic                   pop_o,
	output logic                   txd_o,
	output logic                   done_o
);

	localparam logic [3:0] LAST_TICK = 4'(`USART_OVERSAMPLE - 1);

	usart_pkg::tx_state_e state;
	logic [3:0]  tick_cnt;
	logic [3:0]  bit_cnt;     // Bits left in the frame
	logic [3:0]  nbits;
	logic [3:0]  frame_len;
	logic [11:0] shifter;
	logic [11:0] frame;
	logic [7:0]  data_m;
	logic        par_en;
	logic        par_bit;
	logic        bit_end;

	assign nbits     = 4'd5 + {2'b00, ctrl_i.char_size};
	assign par_en    = (ctrl_i.parity == usart_pkg::PAR_EVEN) ||
	                   (ctrl_i.parity == usart_pkg::PAR_ODD);
	assign data_m    = fifo_data_i & (8'hFF >> (2'd3 - ctrl_i.char_size));
	assign par_bit   = ^data_m ^ (ctrl_i.parity == usart_pkg::PAR_ODD);
	assign frame_len = nbits + 4'd2 + {3'b000, par_en} + {3'b000, ctrl_i.two_stop};

	// Start, data LSB first, parity, stop bits fill from the ones
	always_comb begin
		frame    = '1;
		frame[0] = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if (i < int'(nbits))
				frame[i + 1] = data_m[i];
		end
		if (par_en)
			frame[nbits + 4'd1] = par_bit;
	end

	// Start only on a tick so every bit spans whole tick periods
	assign pop_o   = (state == usart_pkg::TX_IDLE) && ctrl_i.txen && !fifo_empty_i && tick_i;
	assign bit_end = (state == usart_pkg::TX_SHIFT) && tick_i && (tick_cnt == LAST_TICK);
	assign done_o  = bit_end && (bit_cnt == 4'd1);
	assign txd_o   = (state == usart_pkg::TX_SHIFT) ? shifter[0] : 1'b1;

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			state    <= usart_pkg::TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			case (state)
				usart_pkg::TX_IDLE:
					if (pop_o) begin
						state    <= usart_pkg::TX_SHIFT;
						tick_cnt <= '0;
						bit_cnt  <= frame_len;
					end
				usart_pkg::TX_SHIFT: begin
					if (tick_i)
						tick_cnt <= (tick_cnt == LAST_TICK) ? 4'd0 : tick_cnt + 4'd1;
					if (bit_end)
						bit_cnt <= bit_cnt - 4'd1;
					if (done_o)
						state <= usart_pkg::TX_IDLE;
				end
				default:
					state <= usart_pkg::TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge cp2) begin
		if (pop_o)
			shifter <= frame;
		else if (bit_end)
			shifter <= {1'b1, shifter[11:1]};
	end

endmodule

/* usart_regs.sv */
`include "usart_config.svh"

module usart_regs (
	input  logic                   cp2,
	input  logic                   ireset,
	input  logic [11:0]            addr_i,
	input  logic                   re_i,
	input  logic                   we_i,
	input  logic [7:0]             dat_i,
	output logic [7:0]             dat_o,
	output logic                   out_en_o,
	output usart_pkg::usart_ctrl_t ctrl_o,
	output logic [11:0]            divisor_o,
	output logic                   div_load_o,
	input  usart_pkg::rx_frame_t   rx_head_i,
	input  logic                   rx_empty_i,
	output logic                   rx_pop_o,
	input  logic                   rx_overrun_i,
	input  logic                   tx_full_i,
	output logic                   tx_push_o,
	output logic [7:0]             tx_data_o,
	input  logic                   tx_done_i,
	output logic                   rxc_irq_o,
	output logic                   udre_irq_o,
	output logic                   txc_irq_o
);

	usart_pkg::ucsra_t ucsra;
	usart_pkg::ucsrb_t ucsrb;
	usart_pkg::ucsrc_t ucsrc;
	logic [11:0] ubrr;
	logic [3:0]  ubrrh_tmp;   // High byte waits for the low byte write
	logic        txc;
	logic        dor;
	logic        wr_udr;
	logic        rd_udr;
	logic        wr_ucsra;
	logic        wr_ucsrb;
	logic        wr_ucsrc;
	logic        wr_ubrrh;
	logic        wr_ubrrl;

	assign wr_udr   = we_i && (addr_i == `USART_UDR_ADDR);
	assign rd_udr   = re_i && (addr_i == `USART_UDR_ADDR);
	assign wr_ucsra = we_i && (addr_i == `USART_UCSRA_ADDR);
	assign wr_ucsrb = we_i && (addr_i == `USART_UCSRB_ADDR);
	assign wr_ucsrc = we_i && (addr_i == `USART_UCSRC_ADDR);
	assign wr_ubrrh = we_i && (addr_i == `USART_UBRRH_ADDR);
	assign wr_ubrrl = we_i && (addr_i == `USART_UBRRL_ADDR);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			ucsrb      <= '0;
			ucsrc      <= usart_pkg::ucsrc_t'(8'h06);   // 8 data bits
			ubrr       <= '0;
			ubrrh_tmp  <= '0;
			div_load_o <= 1'b0;
			txc        <= 1'b0;
			dor        <= 1'b0;
		end else begin
			if (wr_ucsrb)
				ucsrb <= usart_pkg::ucsrb_t'({dat_i[7:3], 3'b000});
			if (wr_ucsrc)
				ucsrc <= usart_pkg::ucsrc_t'(dat_i);
			if (wr_ubrrh)
				ubrrh_tmp <= dat_i[3:0];
			if (wr_ubrrl)
				ubrr <= {ubrrh_tmp, dat_i};
			div_load_o <= wr_ubrrl;   // Restart the baud counter with the new value
			if (tx_done_i)
				txc <= 1'b1;
			else if (wr_ucsra && dat_i[6])
				txc <= 1'b0;   // Write one to clear
			if (rx_overrun_i)
				dor <= 1'b1;
			else if (rd_udr || wr_ucsra)
				dor <= 1'b0;
		end
	end

	// Error flags belong to the byte at the FIFO head
	always_comb begin
		ucsra.rxc  = !rx_empty_i;
		ucsra.txc  = txc;
		ucsra.udre = !tx_full_i;
		ucsra.fe   = rx_head_i.fe && !rx_empty_i;
		ucsra.dor  = dor;
		ucsra.upe  = rx_head_i.pe && !rx_empty_i;
		ucsra.rsvd = 2'b00;
	end

	always_comb begin
		case (addr_i)
			`USART_UDR_ADDR: begin
				dat_o    = rx_empty_i ? 8'h00 : rx_head_i.data;
				out_en_o = re_i;
			end
			`USART_UCSRA_ADDR: begin
				dat_o    = ucsra;
				out_en_o = re_i;
			end
			`USART_UCSRB_ADDR: begin
				dat_o    = ucsrb;
				out_en_o = re_i;
			end
			`USART_UCSRC_ADDR: begin
				dat_o    = ucsrc;
				out_en_o = re_i;
			end
			`USART_UBRRH_ADDR: begin
				dat_o    = {4'b0000, ubrr[11:8]};
				out_en_o = re_i;
			end
			`USART_UBRRL_ADDR: begin
				dat_o    = ubrr[7:0];
				out_en_o = re_i;
			end
			default: begin
				dat_o    = 8'h00;
				out_en_o = 1'b0;
			end
		endcase
	end

	assign ctrl_o.rxen      = ucsrb.rxen;
	assign ctrl_o.txen      = ucsrb.txen;
	assign ctrl_o.char_size = ucsrc.ucsz;
	assign ctrl_o.parity    = usart_pkg::parity_e'(ucsrc.upm);
	assign ctrl_o.two_stop  = ucsrc.usbs;

	assign divisor_o = ubrr;
	assign rx_pop_o  = rd_udr;
	assign tx_push_o = wr_udr && ucsrb.txen && !tx_full_i;   // Dropped while udre is low
	assign tx_data_o = dat_i;

	assign rxc_irq_o  = ucsrb.rxcie && ucsra.rxc;
	assign udre_irq_o = ucsrb.udrie && ucsra.udre;
	assign txc_irq_o  = ucsrb.txcie && ucsra.txc;

endmodule

/* usart_top.sv */
`include "usart_config.svh"

module usart_top (
	input  logic        cp2,
	input  logic        ireset,
	input  logic [11:0] addr_i,
	input  logic        re_i,
	input  logic        we_i,
	input  logic [7:0]  dat_i,
	output logic [7:0]  dat_o,
	output logic        out_en_o,
	input  logic        rxd_i,
	output logic        txd_o,
	output logic        rxc_irq_o,
	output logic        udre_irq_o,
	output logic        txc_irq_o
);

	usart_pkg::usart_ctrl_t ctrl;
	usart_pkg::rx_frame_t   rx_frame;
	usart_pkg::rx_frame_t   rx_head;
	logic [11:0] divisor;
	logic        div_load;
	logic        tick;
	logic        rx_push;
	logic        rx_pop;
	logic        rx_overrun;
	logic        rx_empty;
	logic        rx_full;
	logic        tx_push;
	logic        tx_pop;
	logic        tx_empty;
	logic        tx_full;
	logic        tx_done;
	logic [7:0]  tx_data;
	logic [7:0]  tx_byte;

	usart_regs i_usart_regs (
		.cp2          (cp2),
		.ireset       (ireset),
		.addr_i       (addr_i),
		.re_i         (re_i),
		.we_i         (we_i),
		.dat_i        (dat_i),
		.dat_o        (dat_o),
		.out_en_o     (out_en_o),
		.ctrl_o       (ctrl),
		.divisor_o    (divisor),
		.div_load_o   (div_load),
		.rx_head_i    (rx_head),
		.rx_empty_i   (rx_empty),
		.rx_pop_o     (rx_pop),
		.rx_overrun_i (rx_overrun),
		.tx_full_i    (tx_full),
		.tx_push_o    (tx_push),
		.tx_data_o    (tx_data),
		.tx_done_i    (tx_done),
		.rxc_irq_o    (rxc_irq_o),
		.udre_irq_o   (udre_irq_o),
		.txc_irq_o    (txc_irq_o)
	);

	usart_baud_gen i_usart_baud_gen (
		.cp2       (cp2),
		.ireset    (ireset),
		.divisor_i (divisor),
		.load_i    (div_load),
		.tick_o    (tick)
	);

	// Disabling the receiver empties the receive FIFO
	usart_fifo #(
		.DEPTH (`USART_RX_DEPTH),
		.WIDTH ($bits(usart_pkg::rx_frame_t))
	) i_rx_fifo (
		.cp2     (cp2),
		.ireset  (ireset),
		.flush_i (!ctrl.rxen),
		.push_i  (rx_push),
		.data_i  (rx_frame),
		.pop_i   (rx_pop),
		.data_o  (rx_head),
		.empty_o (rx_empty),
		.full_o  (rx_full)
	);

	usart_fifo #(
		.DEPTH (`USART_TX_DEPTH),
		.WIDTH (8)
	) i_tx_fifo (
		.cp2     (cp2),
		.ireset  (ireset),
		.flush_i (!ctrl.txen),
		.push_i  (tx_push),
		.data_i  (tx_data),
		.pop_i   (tx_pop),
		.data_o  (tx_byte),
		.empty_o (tx_empty),
		.full_o  (tx_full)
	);

	usart_rx i_usart_rx (
		.cp2         (cp2),
		.ireset      (ireset),
		.ctrl_i      (ctrl),
		.tick_i      (tick),
		.rxd_i       (rxd_i),
		.fifo_full_i (rx_full),
		.frame_o     (rx_frame),
		.push_o      (rx_push),
		.overrun_o   (rx_overrun)
	);

	usart_tx i_usart_tx (
		.cp2          (cp2),
		.ireset       (ireset),
		.ctrl_i       (ctrl),
		.tick_i       (tick),
		.fifo_empty_i (tx_empty),
		.fifo_data_i  (tx_byte),
		.pop_o        (tx_pop),
		.txd_o        (txd_o),
		.done_o       (tx_done)
	);

endmodule

/* tb_usart.sv */
`include "usart_config.svh"

module tb_usart;

	// One line of the case file
	typedef struct packed {
		logic [1:0]  char_size;
		logic [1:0]  parity;
		logic        two_stop;
		logic [11:0] divisor;
		logic [7:0]  data;
		logic [1:0]  err;   // 0 none, 1 bad parity, 2 bad stop, 3 overrun
	} test_case_t;

	localparam logic [7:0] RXC_BIT = 8'h80;
	localparam logic [7:0] TXC_BIT = 8'h40;
	localparam logic [7:0] DOR_BIT = 8'h08;

	logic        cp2;
	logic        ireset;
	logic [11:0] addr_i;
	logic        re_i;
	logic        we_i;
	logic [7:0]  dat_i;
	logic [7:0]  dat_o;
	logic        out_en_o;
	logic        rxd_i;
	logic        txd_o;
	logic        rxc_irq_o;
	logic        udre_irq_o;
	logic        txc_irq_o;
	logic        rxd_drv;
	logic        loopback;
	logic [31:0] lfsr;
	int          bit_cycles;
	int          cycle_count;
	int          cycle_limit;
	test_case_t  cases[$];

	assign rxd_i = loopback ? txd_o : rxd_drv;   // Error frames come from the testbench

	usart_top i_usart_top (
		.cp2        (cp2),
		.ireset     (ireset),
		.addr_i     (addr_i),
		.re_i       (re_i),
		.we_i       (we_i),
		.dat_i      (dat_i),
		.dat_o      (dat_o),
		.out_en_o   (out_en_o),
		.rxd_i      (rxd_i),
		.txd_o      (txd_o),
		.rxc_irq_o  (rxc_irq_o),
		.udre_irq_o (udre_irq_o),
		.txc_irq_o  (txc_irq_o)
	);

	always #10 cp2 = ~cp2;

	task automatic fail_and_stop();
		$display("Errors found");
		$fatal(1);
	endtask

	always @(posedge cp2) begin
		cycle_count++;
		if (cycle_limit != 0 && cycle_count > cycle_limit) begin
			$display("Timeout after %0d clock cycles, the DUT did not finish", cycle_limit);
			fail_and_stop();
		end
	end

	task automatic check_status(input string name, input usart_pkg::ucsra_t got,
			input usart_pkg::ucsra_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is 0x%02h, expected 0x%02h", $time, name, got, exp);
			fail_and_stop();
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is 0x%02h, expected 0x%02h", $time, name, got, exp);
			fail_and_stop();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
			fail_and_stop();
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic next_random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b[i] = lfsr[0];
		end
	endtask

	function automatic logic [7:0] mask_data(input logic [7:0] d, input int char_size);
		return d & 8'((1 << (char_size + 5)) - 1);
	endfunction

	function automatic logic parity_on(input int par);
		return (par == 2) || (par == 3);
	endfunction

	function automatic logic expected_parity(input logic [7:0] d, input int par);
		return (^d) ^ (par == 3);   // Odd parity inverts
	endfunction

	// udre stays set wherever status is checked
	function automatic usart_pkg::ucsra_t make_status(input logic rxc, input logic txc,
			input logic fe, input logic dor, input logic upe);
		usart_pkg::ucsra_t s;
		s      = '0;
		s.rxc  = rxc;
		s.txc  = txc;
		s.udre = 1'b1;
		s.fe   = fe;
		s.dor  = dor;
		s.upe  = upe;
		return s;
	endfunction

	task automatic write_reg(input logic [11:0] addr, input logic [7:0] data);
		@(negedge cp2);
		addr_i = addr;
		dat_i  = data;
		we_i   = 1'b1;
		@(negedge cp2);
		we_i = 1'b0;
	endtask

	task automatic read_reg(input logic [11:0] addr, output logic [7:0] data);
		@(negedge cp2);
		addr_i = addr;
		re_i   = 1'b1;
		#5;   // Mid low phase, read data settled
		check_bit("out_en_o", out_en_o, 1'b1);
		data = dat_o;
		@(negedge cp2);
		re_i = 1'b0;
	endtask

	task automatic read_status(output usart_pkg::ucsra_t s);
		logic [7:0] raw;
		read_reg(`USART_UCSRA_ADDR, raw);
		s = usart_pkg::ucsra_t'(raw);
	endtask

	// Poll status A until a flag in mask sets
	task automatic wait_status(input logic [7:0] mask);
		logic [7:0] raw;
		raw = 8'h00;
		while ((raw & mask) == 8'h00)
			read_reg(`USART_UCSRA_ADDR, raw);
	endtask

	// Sample txd_o mid bit, timed from the start bit's falling edge
	task automatic expect_tx_frame(input test_case_t tc);
		logic [7:0] d;
		int nbits;
		d = mask_data(tc.data, int'(tc.char_size));
		nbits = int'(tc.char_size) + 5;
		while (txd_o !== 1'b0)
			@(negedge cp2);
		repeat (bit_cycles / 2) @(negedge cp2);
		check_bit("txd_o", txd_o, 1'b0);
		for (int i = 0; i < nbits; i++) begin
			repeat (bit_cycles) @(negedge cp2);
			check_bit("txd_o", txd_o, d[i]);
		end
		if (parity_on(int'(tc.parity))) begin
			repeat (bit_cycles) @(negedge cp2);
			check_bit("txd_o", txd_o, expected_parity(d, int'(tc.parity)));
		end
		for (int i = 0; i <= int'(tc.two_stop); i++) begin
			repeat (bit_cycles) @(negedge cp2);
			check_bit("txd_o", txd_o, 1'b1);
		end
	endtask

	task automatic drive_rx_bit(input logic b);
		@(negedge cp2);
		rxd_drv = b;
		repeat (bit_cycles - 1) @(negedge cp2);
	endtask

	task automatic drive_rx_frame(input test_case_t tc, input logic [7:0] d,
			input logic bad_par, input logic bad_stop);
		drive_rx_bit(1'b0);
		for (int i = 0; i < int'(tc.char_size) + 5; i++)
			drive_rx_bit(d[i]);
		if (parity_on(int'(tc.parity)))
			drive_rx_bit(expected_parity(d, int'(tc.parity)) ^ bad_par);
		drive_rx_bit(!bad_stop);   // Receiver checks only the first stop bit
		if (tc.two_stop)
			drive_rx_bit(1'b1);
	endtask

	task automatic setup_case(input test_case_t tc, input logic ie);
		usart_pkg::ucsra_t st;
		bit_cycles = `USART_OVERSAMPLE * (int'(tc.divisor) + 1);
		@(negedge cp2);
		loopback = (tc.err == 2'd0);
		rxd_drv  = 1'b1;
		write_reg(`USART_UCSRB_ADDR, 8'h00);   // Flushes both FIFOs
		write_reg(`USART_UCSRA_ADDR, TXC_BIT);
		write_reg(`USART_UCSRC_ADDR, {2'b00, tc.parity, tc.two_stop, tc.char_size, 1'b0});
		write_reg(`USART_UBRRH_ADDR, {4'h0, tc.divisor[11:8]});
		write_reg(`USART_UBRRL_ADDR, tc.divisor[7:0]);
		write_reg(`USART_UCSRB_ADDR, {ie, ie, ie, 2'b11, 3'b000});
		read_status(st);
		check_status("UCSRA", st, make_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
		check_bit("rxc_irq_o", rxc_irq_o, 1'b0);
		check_bit("txc_irq_o", txc_irq_o, 1'b0);
		check_bit("udre_irq_o", udre_irq_o, ie);
	endtask

	task automatic run_loopback(input test_case_t tc, input logic ie);
		usart_pkg::ucsra_t st;
		logic [7:0] rd;
		write_reg(`USART_UDR_ADDR, tc.data);
		expect_tx_frame(tc);
		wait_status(TXC_BIT);   // Receiver finishes mid stop bit, well before txc
		read_status(st);
		check_status("UCSRA", st, make_status(1'b1, 1'b1, 1'b0, 1'b0, 1'b0));
		check_bit("rxc_irq_o", rxc_irq_o, ie);
		check_bit("txc_irq_o", txc_irq_o, ie);
		check_bit("udre_irq_o", udre_irq_o, ie);
		read_reg(`USART_UDR_ADDR, rd);
		check_byte("UDR", rd, mask_data(tc.data, int'(tc.char_size)));
		read_status(st);
		check_status("UCSRA", st, make_status(1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
		check_bit("rxc_irq_o", rxc_irq_o, 1'b0);
		write_reg(`USART_UCSRA_ADDR, TXC_BIT);
		read_status(st);
		check_status("UCSRA", st, make_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
		check_bit("txc_irq_o", txc_irq_o, 1'b0);
	endtask

	task automatic run_error_frame(input test_case_t tc, input logic ie);
		usart_pkg::ucsra_t st;
		logic [7:0] d;
		logic [7:0] rd;
		d = mask_data(tc.data, int'(tc.char_size));
		drive_rx_frame(tc, d, tc.err == 2'd1, tc.err == 2'd2);
		drive_rx_bit(1'b1);   // Idle line so a low stop bit is not read as a start
		wait_status(RXC_BIT);
		read_status(st);
		check_status("UCSRA", st, make_status(1'b1, 1'b0, tc.err == 2'd2, 1'b0, tc.err == 2'd1));
		check_bit("rxc_irq_o", rxc_irq_o, ie);
		read_reg(`USART_UDR_ADDR, rd);
		check_byte("UDR", rd, d);
		read_status(st);
		check_status("UCSRA", st, make_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
	endtask

	// Third frame finds the two-entry FIFO full
	task automatic run_overrun(input test_case_t tc);
		usart_pkg::ucsra_t st;
		logic [7:0] d0;
		logic [7:0] d1;
		logic [7:0] d2;
		logic [7:0] rd;
		d0 = mask_data(tc.data, int'(tc.char_size));
		next_random_byte(rd);
		d1 = mask_data(rd, int'(tc.char_size));
		next_random_byte(rd);
		d2 = mask_data(rd, int'(tc.char_size));
		drive_rx_frame(tc, d0, 1'b0, 1'b0);
		drive_rx_frame(tc, d1, 1'b0, 1'b0);
		drive_rx_frame(tc, d2, 1'b0, 1'b0);
		wait_status(DOR_BIT);
		read_status(st);
		check_status("UCSRA", st, make_status(1'b1, 1'b0, 1'b0, 1'b1, 1'b0));
		read_reg(`USART_UDR_ADDR, rd);
		check_byte("UDR", rd, d0);
		read_reg(`USART_UDR_ADDR, rd);
		check_byte("UDR", rd, d1);
		read_status(st);
		check_status("UCSRA", st, make_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
	endtask

	task automatic load_cases();
		int fd;
		int n;
		int f_cs;
		int f_par;
		int f_two;
		int f_div;
		int f_data;
		int f_err;
		test_case_t tc;
		fd = $fopen("usart_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test case file usart_cases.txt");
			fail_and_stop();
		end else begin
			n = $fscanf(fd, "%d %d %d %d %h %d", f_cs, f_par, f_two, f_div, f_data, f_err);
			while (n == 6) begin
				tc.char_size = f_cs[1:0];
				tc.parity    = f_par[1:0];
				tc.two_stop  = f_two[0];
				tc.divisor   = f_div[11:0];
				tc.data      = f_data[7:0];
				tc.err       = f_err[1:0];
				cases.push_back(tc);
				cycle_limit += 3 * 12 * `USART_OVERSAMPLE * (f_div + 1);   // Three 12-bit frames
				n = $fscanf(fd, "%d %d %d %d %h %d", f_cs, f_par, f_two, f_div, f_data, f_err);
			end
			$fclose(fd);
		end
	endtask

	initial begin
		logic [7:0] rd;
		logic ie;
		usart_pkg::ucsra_t st;
		cp2         = 1'b0;
		ireset      = 1'b0;
		addr_i      = '0;
		re_i        = 1'b0;
		we_i        = 1'b0;
		dat_i       = '0;
		rxd_drv     = 1'b1;
		loopback    = 1'b0;
		lfsr        = 32'heb2a1c25;
		bit_cycles  = `USART_OVERSAMPLE;
		cycle_count = 0;
		cycle_limit = 0;
		load_cases();
		if (cases.size() == 0) begin
			$display("The test case file holds no usable lines");
			fail_and_stop();
		end
		cycle_limit += 2000;
		repeat (4) @(negedge cp2);
		ireset = 1'b1;

		// Reset values
		check_bit("out_en_o", out_en_o, 1'b0);
		check_bit("txd_o", txd_o, 1'b1);
		check_bit("rxc_irq_o", rxc_irq_o, 1'b0);
		check_bit("udre_irq_o", udre_irq_o, 1'b0);
		check_bit("txc_irq_o", txc_irq_o, 1'b0);
		read_status(st);
		check_status("UCSRA", st, make_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
		read_reg(`USART_UCSRC_ADDR, rd);
		check_byte("UCSRC", rd, 8'h06);
		read_reg(`USART_UCSRB_ADDR, rd);
		check_byte("UCSRB", rd, 8'h00);
		read_reg(`USART_UBRRH_ADDR, rd);
		check_byte("UBRRH", rd, 8'h00);
		read_reg(`USART_UBRRL_ADDR, rd);
		check_byte("UBRRL", rd, 8'h00);

		// High byte only lands with the low byte
		write_reg(`USART_UBRRH_ADDR, 8'h0A);
		read_reg(`USART_UBRRH_ADDR, rd);
		check_byte("UBRRH", rd, 8'h00);
		write_reg(`USART_UBRRL_ADDR, 8'h5B);
		read_reg(`USART_UBRRH_ADDR, rd);
		check_byte("UBRRH", rd, 8'h0A);
		read_reg(`USART_UBRRL_ADDR, rd);
		check_byte("UBRRL", rd, 8'h5B);

		foreach (cases[i]) begin
			ie = 1'(i % 2);   // Interrupt enables on every other case
			setup_case(cases[i], ie);
			case (cases[i].err)
				2'd0: run_loopback(cases[i], ie);
				2'd3: run_overrun(cases[i]);
				default: run_error_frame(cases[i], ie);
			endcase
		end

		$display("No errors");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+.
usart_pkg.sv
usart_baud_gen.sv
usart_fifo.sv
usart_rx.sv
usart_tx.sv
usart_regs.sv
usart_top.sv
tb_usart.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_usart
FILELIST  = filelist.f
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* usart_cases.txt */
3 0 0 1 a5 0
0 2 0 0 15 0
1 3 1 2 2c 0
2 2 0 3 5b 0
3 3 1 1 c3 0
3 1 0 2 7e 0
0 0 1 1 1f 0
1 0 0 0 33 0
2 3 0 1 49 0
3 2 1 0 ff 0
3 2 0 1 6d 1
1 3 0 2 0a 1
0 2 1 1 11 1
3 3 1 0 80 1
3 0 0 1 96 2
2 2 0 0 3c 2
0 0 1 2 07 2
1 3 1 1 1d 2
3 0 0 1 5a 3
2 3 1 0 24 3
0 2 0 2 0e 3
1 0 1 1 19 3
3 2 0 3 e1 0
3 0 1 0 00 0
2 0 0 5 62 0
